// File: bram.sv
`timescale 1ns/1ps

module bram (
	input logic i_clock,
	input logic i_arst_n,
	soc_bus_if.target bus
);
	import soc_pkg::*;

	bus_data_t mem [0:RAM_WORDS-1];
	bus_data_t rdata;
	ram_index_t index;
	logic ready;
	logic start;

	// Word index from the offset address
	assign index = bus.address[9:2];

	// First edge of a new access
	assign start = bus.request && !ready;

	// Read returns the old word even when the same access writes
	always_ff @(posedge i_clock) begin
		if (start) begin
			if (bus.rw) begin
				mem[index] <= bus.wdata;
			end
			rdata <= mem[index];
		end
	end

	// Ready stays up until request is released
	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			ready <= 1'b0;
		end else if (start) begin
			ready <= 1'b1;
		end else if (!bus.request) begin
			ready <= 1'b0;
		end
	end

	assign bus.rdata = rdata;
	assign bus.ready = ready;

endmodule

// File: bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder (
	input logic i_request,
	input logic i_rw,
	input soc_pkg::bus_addr_t i_address,
	input soc_pkg::bus_data_t i_wdata,
	output soc_pkg::bus_data_t o_rdata,
	output logic o_ready,
	soc_bus_if.master ram,
	soc_bus_if.master led,
	soc_bus_if.master uart
);
	import soc_pkg::*;

	logic ram_select;
	logic led_select;
	logic uart_select;
	logic target_ready;

	// Region match
	assign ram_select = (i_address >= RAM_BASE) && (i_address < RAM_LIMIT);
	assign led_select = (i_address >= LED_BASE) && (i_address < LED_BASE + IO_SPAN);
	assign uart_select = (i_address >= UART_BASE) && (i_address < UART_BASE + IO_SPAN);

	// RAM port
	assign ram.request = i_request && ram_select;
	assign ram.rw = i_rw;
	assign ram.address = i_address - RAM_BASE;
	assign ram.wdata = i_wdata;

	// LED port
	assign led.request = i_request && led_select;
	assign led.rw = i_rw;
	assign led.address = i_address - LED_BASE;
	assign led.wdata = i_wdata;

	// UART port
	assign uart.request = i_request && uart_select;
	assign uart.rw = i_rw;
	assign uart.address = i_address - UART_BASE;
	assign uart.wdata = i_wdata;

	// Read data back from whichever region is addressed
	always_comb begin
		if (ram_select) begin
			o_rdata = ram.rdata;
		end else if (led_select) begin
			o_rdata = led.rdata;
		end else if (uart_select) begin
			o_rdata = uart.rdata;
		end else begin
			o_rdata = '0;
		end
	end

	// Unmapped space answers at once so the master never stalls
	always_comb begin
		if (ram_select) begin
			target_ready = ram.ready;
		end else if (led_select) begin
			target_ready = led.ready;
		end else if (uart_select) begin
			target_ready = uart.ready;
		end else begin
			target_ready = 1'b1;
		end
	end

	// Targets hold ready one cycle past request, hide that from the master
	assign o_ready = i_request && target_ready;

endmodule

// File: led_port.sv
`timescale 1ns/1ps

module led_port (
	input logic i_clock,
	input logic i_arst_n,
	soc_bus_if.target bus,
	output soc_pkg::led_t o_ledr
);
	import soc_pkg::*;

	logic ready;
	logic start;

	assign start = bus.request && !ready;

	// LED register and handshake
	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_ledr <= '0;
			ready <= 1'b0;
		end else if (start) begin
			if (bus.rw) begin
				o_ledr <= bus.wdata[$bits(led_t)-1:0];
			end
			ready <= 1'b1;
		end else if (!bus.request) begin
			ready <= 1'b0;
		end
	end

	// Read back, upper bits zero
	assign bus.rdata = {{($bits(bus_data_t) - $bits(led_t)){1'b0}}, o_ledr};
	assign bus.ready = ready;

endmodule

// File: soc.f
soc_pkg.sv
soc_bus_if.sv
bus_decoder.sv
bram.sv
led_port.sv
uart_tx.sv
soc.sv
soc_properties.sv
tb_soc.sv

// File: soc.sv
`timescale 1ns/1ps

module soc (
	input logic i_clock,
	input logic i_arst_n,

	// Bus from the master
	input logic i_bus_request,
	input logic i_bus_rw,
	input soc_pkg::bus_addr_t i_bus_address,
	input soc_pkg::bus_data_t i_bus_wdata,
	output soc_pkg::bus_data_t o_bus_rdata,
	output logic o_bus_ready,

	// Board pins
	output soc_pkg::led_t o_ledr,
	output logic o_uart_tx
);

	// One bus per target
	soc_bus_if ram_bus();
	soc_bus_if led_bus();
	soc_bus_if uart_bus();

	// Address decode and return mux
	bus_decoder u_decoder (
		.i_request(i_bus_request),
		.i_rw(i_bus_rw),
		.i_address(i_bus_address),
		.i_wdata(i_bus_wdata),
		.o_rdata(o_bus_rdata),
		.o_ready(o_bus_ready),
		.ram(ram_bus.master),
		.led(led_bus.master),
		.uart(uart_bus.master)
	);

	// RAM at 0x00010000
	bram u_ram (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.bus(ram_bus.target)
	);

	// LEDs at 0x50000000
	led_port u_led (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.bus(led_bus.target),
		.o_ledr(o_ledr)
	);

	// UART at 0x50000010
	uart_tx u_uart (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.bus(uart_bus.target),
		.o_tx(o_uart_tx)
	);

endmodule

// File: soc_bus_if.sv
`timescale 1ns/1ps

interface soc_bus_if;
	import soc_pkg::*;

	logic request;
	logic rw;
	bus_addr_t address;
	bus_data_t wdata;
	bus_data_t rdata;
	logic ready;

	// Decoder side
	modport master (
		output request, rw, address, wdata,
		input rdata, ready
	);

	// Peripheral side, address is already relative to the base
	modport target (
		input request, rw, address, wdata,
		output rdata, ready
	);

endinterface

// File: soc_pkg.sv
package soc_pkg;

	// Bus word types
	typedef logic [31:0] bus_addr_t;
	typedef logic [31:0] bus_data_t;

	// RAM word index, address bits 9 to 2
	typedef logic [7:0] ram_index_t;

	// Red LED bank
	typedef logic [9:0] led_t;

	// Serial payload
	typedef logic [7:0] uart_byte_t;

	// Transmitter phases of one 8N1 frame
	typedef enum logic [1:0] {
		UART_IDLE,
		UART_START,
		UART_DATA,
		UART_STOP
	} uart_state_t;

	// Address map
	localparam bus_addr_t RAM_BASE = 32'h0001_0000;
	localparam bus_addr_t RAM_LIMIT = 32'h0001_0400;
	localparam int RAM_WORDS = 256;
	localparam bus_addr_t LED_BASE = 32'h5000_0000;
	localparam bus_addr_t UART_BASE = 32'h5000_0010;
	// Each peripheral owns 16 bytes
	localparam bus_addr_t IO_SPAN = 32'h0000_0010;

	// Short bit time for simulation
	localparam int UART_CLKS_PER_BIT = 8;
	localparam int UART_CNT_W = $clog2(UART_CLKS_PER_BIT);

endpackage

// File: soc_properties.sv
`timescale 1ns/1ps

module soc_properties (
	input logic i_clock,
	input logic i_arst_n,
	input logic i_bus_request,
	input soc_pkg::bus_addr_t i_bus_address,
	input logic i_bus_ready,
	input logic i_uart_tx,
	input soc_pkg::uart_state_t i_uart_state
);
	import soc_pkg::*;

	int unsigned failures = 0;

	// Ready only answers a live request
	ready_needs_request: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		i_bus_ready |-> i_bus_request)
		else begin
			$error("Bus ready high while request is low");
			failures++;
		end

	// Master keeps request and address until the target answers
	request_held: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		i_bus_request && !i_bus_ready |=> i_bus_request && $stable(i_bus_address))
		else begin
			$error("Bus request or address changed before ready");
			failures++;
		end

	// Line idles high out of reset
	tx_high_after_reset: assert property (@(posedge i_clock)
		$rose(i_arst_n) |-> i_uart_tx)
		else begin
			$error("UART line not high after reset");
			failures++;
		end

	tx_idle_high: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		i_uart_state == UART_IDLE |-> i_uart_tx)
		else begin
			$error("UART line low while transmitter is idle");
			failures++;
		end

endmodule

bind soc soc_properties props (
	.i_clock(i_clock),
	.i_arst_n(i_arst_n),
	.i_bus_request(i_bus_request),
	.i_bus_address(i_bus_address),
	.i_bus_ready(o_bus_ready),
	.i_uart_tx(o_uart_tx),
	.i_uart_state(u_uart.state)
);

// File: tb_soc.sv
`timescale 1ns/1ps

module tb_soc;
	import soc_pkg::*;

	localparam time DRIVE_DELAY = 5ns;
	localparam int TIMEOUT_CYCLES = 200;

	logic i_clock;
	logic i_arst_n;
	logic i_bus_request;
	logic i_bus_rw;
	bus_addr_t i_bus_address;
	bus_data_t i_bus_wdata;
	bus_data_t o_bus_rdata;
	logic o_bus_ready;
	led_t o_ledr;
	logic o_uart_tx;

	// Reference model
	bus_data_t ram_model [0:RAM_WORDS-1];
	led_t led_model;
	uart_byte_t uart_expected [$];
	int frames_seen;

	soc dut (.*);

	initial begin
		i_clock = 1'b0;
		forever #50 i_clock = ~i_clock;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Verification failed");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic check_data(input string test, input bus_data_t expected,
			input bus_data_t actual);
		if (actual !== expected)
			abort_run($sformatf("FAIL %s: expected %h, actual %h", test, expected, actual));
	endtask

	task automatic check_led(input string test, input led_t expected, input led_t actual);
		if (actual !== expected)
			abort_run($sformatf("FAIL %s: expected %h, actual %h", test, expected, actual));
	endtask

	task automatic check_byte(input string test, input uart_byte_t expected,
			input uart_byte_t actual);
		if (actual !== expected)
			abort_run($sformatf("FAIL %s: expected %h, actual %h", test, expected, actual));
	endtask

	// One full handshake, request held until ready then released
	task automatic bus_access(input bus_addr_t addr, input logic write, input bus_data_t wdata,
			output bus_data_t rdata);
		int cycles;
		@(posedge i_clock);
		#DRIVE_DELAY;
		i_bus_request = 1'b1;
		i_bus_rw = write;
		i_bus_address = addr;
		i_bus_wdata = wdata;
		cycles = 0;
		do begin
			@(negedge i_clock);
			cycles++;
			if (cycles > TIMEOUT_CYCLES) abort_run("Bus ready never rose");
		end while (!o_bus_ready);
		rdata = o_bus_rdata;
		@(posedge i_clock);
		#DRIVE_DELAY;
		i_bus_request = 1'b0;
		cycles = 0;
		do begin
			@(negedge i_clock);
			cycles++;
			if (cycles > TIMEOUT_CYCLES) abort_run("Bus ready stayed high after request");
		end while (o_bus_ready);
	endtask

	task automatic bus_write(input bus_addr_t addr, input bus_data_t data);
		bus_data_t unused;
		bus_access(addr, 1'b1, data, unused);
	endtask

	task automatic bus_read(input bus_addr_t addr, output bus_data_t data);
		bus_access(addr, 1'b0, '0, data);
	endtask

	task automatic wait_frames(input int count);
		int cycles;
		cycles = 0;
		while (frames_seen < count) begin
			@(negedge i_clock);
			cycles++;
			if (cycles > TIMEOUT_CYCLES) abort_run("UART frames did not finish");
		end
	endtask

	function automatic logic is_mapped(input bus_addr_t addr);
		return (addr >= RAM_BASE && addr < RAM_LIMIT) ||
			(addr >= LED_BASE && addr < LED_BASE + IO_SPAN) ||
			(addr >= UART_BASE && addr < UART_BASE + IO_SPAN);
	endfunction

	// Protocol checks bound into the DUT
	always @(dut.props.failures) begin
		if (dut.props.failures != 0)
			abort_run("A bus or UART protocol assertion failed");
	end

	// Serial monitor, each bit sampled near its middle
	initial begin
		uart_byte_t got;
		int idle;
		frames_seen = 0;
		idle = 0;
		forever begin
			@(negedge i_clock);
			if (o_uart_tx === 1'b0) begin
				repeat (UART_CLKS_PER_BIT / 2) @(negedge i_clock);
				if (o_uart_tx !== 1'b0) abort_run("UART start bit too short");
				for (int i = 0; i < 8; i++) begin
					repeat (UART_CLKS_PER_BIT) @(negedge i_clock);
					got[i] = o_uart_tx;
				end
				repeat (UART_CLKS_PER_BIT) @(negedge i_clock);
				if (o_uart_tx !== 1'b1) abort_run("UART stop bit missing");
				// Move past the end of the stop bit
				repeat (UART_CLKS_PER_BIT / 2) @(negedge i_clock);
				if (uart_expected.size() == 0) abort_run("UART sent a frame that was never written");
				check_byte("uart frame", uart_expected.pop_front(), got);
				frames_seen++;
				idle = 0;
			end else if (uart_expected.size() != 0) begin
				idle++;
				if (idle > TIMEOUT_CYCLES) abort_run("UART start bit never came");
			end
		end
	end

	initial begin
		bus_data_t rd;
		bus_data_t value;
		bus_addr_t addr;
		ram_index_t idx;
		void'($urandom(83059));
		i_arst_n = 1'b0;
		i_bus_request = 1'b0;
		i_bus_rw = 1'b0;
		i_bus_address = '0;
		i_bus_wdata = '0;
		repeat (2) @(posedge i_clock);
		#DRIVE_DELAY;
		i_arst_n = 1'b1;
		check_led("led after reset", '0, o_ledr);

		// Clear RAM so untouched words read as zero
		for (int i = 0; i < RAM_WORDS; i++) begin
			bus_write(RAM_BASE + (bus_addr_t'(i) << 2), '0);
			ram_model[i] = '0;
		end
		for (int n = 0; n < 200; n++) begin
			idx = ram_index_t'($urandom);
			addr = RAM_BASE + (bus_addr_t'(idx) << 2);
			if ($urandom_range(1, 0)) begin
				value = $urandom;
				bus_write(addr, value);
				ram_model[idx] = value;
			end else begin
				bus_read(addr, rd);
				check_data("ram read", ram_model[idx], rd);
			end
		end

		for (int n = 0; n < 16; n++) begin
			value = $urandom;
			bus_write(LED_BASE + 4 * $urandom_range(3, 0), value);
			led_model = led_t'(value);
			check_led("led pins", led_model, o_ledr);
			bus_read(LED_BASE, rd);
			check_data("led read", bus_data_t'(led_model), rd);
		end

		// Later writes land mid-frame and stall until the line frees up
		for (int n = 0; n < 5; n++) begin
			value = $urandom;
			uart_expected.push_back(uart_byte_t'(value));
			bus_write(UART_BASE, value);
			bus_read(UART_BASE + 4, rd);
			check_data("uart busy after write", 32'd1, rd);
		end
		wait_frames(5);
		bus_read(UART_BASE, rd);
		check_data("uart idle after stop", 32'd0, rd);

		for (int n = 0; n < 20; n++) begin
			case (n)
				0: addr = RAM_BASE - 4;
				1: addr = RAM_LIMIT;
				2: addr = UART_BASE + IO_SPAN;
				default: begin
					addr = $urandom;
					while (is_mapped(addr)) addr = $urandom;
				end
			endcase
			bus_read(addr, rd);
			check_data("unmapped read", '0, rd);
			bus_write(addr, $urandom);
		end
		for (int i = 0; i < RAM_WORDS; i++) begin
			bus_read(RAM_BASE + (bus_addr_t'(i) << 2), rd);
			check_data("ram after unmapped writes", ram_model[i], rd);
		end
		bus_read(LED_BASE, rd);
		check_data("led after unmapped writes", bus_data_t'(led_model), rd);
		check_led("led pins after unmapped writes", led_model, o_ledr);

		$display("Verification passed");
		$finish;
	end

endmodule

// File: uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
	input logic i_clock,
	input logic i_arst_n,
	soc_bus_if.target bus,
	output logic o_tx
);
	import soc_pkg::*;

	uart_state_t state;
	logic [UART_CNT_W-1:0] clk_cnt;
	logic [2:0] bit_idx;
	uart_byte_t shift;
	logic ready;
	logic status;
	logic busy;
	logic bit_done;
	logic accept;

	assign busy = (state != UART_IDLE);
	assign bit_done = (clk_cnt == UART_CNT_W'(UART_CLKS_PER_BIT - 1));

	// Reads always go through, writes wait for an idle line
	assign accept = bus.request && !ready && (!bus.rw || !busy);

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			ready <= 1'b0;
			status <= 1'b0;
		end else if (accept) begin
			ready <= 1'b1;
			status <= busy;
		end else if (!bus.request) begin
			ready <= 1'b0;
		end
	end

	// Shifted out LSB first
	always_ff @(posedge i_clock) begin
		if (accept && bus.rw) begin
			shift <= bus.wdata[7:0];
		end else if (state == UART_DATA && bit_done) begin
			shift <= shift >> 1;
		end
	end

	// Frame sequencer
	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= UART_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
		end else begin
			clk_cnt <= (state == UART_IDLE || bit_done) ? '0 : clk_cnt + 1'b1;
			case (state)
				UART_IDLE: begin
					bit_idx <= '0;
					if (accept && bus.rw) begin
						state <= UART_START;
					end
				end
				UART_START: begin
					if (bit_done) begin
						state <= UART_DATA;
					end
				end
				UART_DATA: begin
					if (bit_done) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= UART_STOP;
						end
					end
				end
				default: begin
					if (bit_done) begin
						state <= UART_IDLE;
					end
				end
			endcase
		end
	end

	// Line level, stop and idle are both high
	always_comb begin
		case (state)
			UART_START: o_tx = 1'b0;
			UART_DATA: o_tx = shift[0];
			default: o_tx = 1'b1;
		endcase
	end

	assign bus.rdata = {{($bits(bus_data_t) - 1){1'b0}}, status};
	assign bus.ready = ready;

endmodule
